// File: build.f
verilog/button_pkg.sv
verilog/button_debouncer.sv
verilog/button_event_encoder.sv
verilog/event_fifo.sv
verilog/press_counter.sv
verilog/button_panel.sv
tests/panel_checker.sv
tests/tb_button_panel.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator and run the button panel testbench
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	-f build.f \
	--top-module tb_button_panel \
	--Mdir obj_dir \
	-o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
	echo "no pass line in sim.log"
	exit 1
fi

// File: tests/tb_button_panel.sv
module tb_button_panel
	import button_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DELAY = 1;

	logic clk;
	logic reset;
	btn_mask_t raw_btn;
	logic drain;
	btn_mask_t level;
	logic event_valid;
	btn_event_t last_event;
	btn_count_t press_total [NUM_BUTTONS];
	btn_count_t release_total [NUM_BUTTONS];
	btn_count_t dropped;

	integer seed = 32'hb92f_d076;
	int tb_errors = 0;
	int events_seen = 0;
	int total_errors;
	int base;
	int rnd;
	btn_event_t seen_q [$];

	button_panel i_dut (
		.clk           (clk),
		.reset         (reset),
		.raw_btn       (raw_btn),
		.drain         (drain),
		.level         (level),
		.event_valid   (event_valid),
		.last_event    (last_event),
		.press_total   (press_total),
		.release_total (release_total),
		.dropped       (dropped)
	);

	panel_checker i_checker (
		.clk           (clk),
		.reset         (reset),
		.raw_btn       (raw_btn),
		.level         (level),
		.event_valid   (event_valid),
		.last_event    (last_event),
		.press_total   (press_total),
		.release_total (release_total),
		.dropped       (dropped)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(negedge clk) begin
		if (!reset && event_valid) begin
			events_seen++;
			seen_q.push_back(last_event);
		end
	end

	task automatic step(int n);
		repeat (n) @(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic wait_events(int target, int limit);
		int i;
		for (i = 0; i < limit && events_seen < target; i++)
			step(1);
		if (events_seen < target) begin
			$display("timeout: only %0d of %0d events arrived", events_seen, target);
			tb_errors++;
		end
	endtask

	// pulses and gaps stay under 14 cycles and end on the starting value
	task automatic bounce_burst(int btn, int pulses);
		for (int k = 0; k < pulses; k++) begin
			raw_btn[btn] = ~raw_btn[btn];
			step(1 + $unsigned($random(seed)) % 13);
			raw_btn[btn] = ~raw_btn[btn];
			step(1 + $unsigned($random(seed)) % 13);
		end
	endtask

	task automatic set_button(int btn, logic value);
		bounce_burst(btn, 3);
		raw_btn[btn] = value;
		step(40);
	endtask

	initial begin
		reset = 1'b1;
		raw_btn = '0;
		drain = 1'b1;
		step(4);
		reset = 1'b0;
		step(2);

		if (level !== '0 || event_valid !== 1'b0 || dropped !== '0) begin
			$display("ERR %0t: outputs not idle after reset", $time);
			tb_errors++;
		end
		i_checker.check_totals();

		// short bounces alone must not produce anything
		for (int b = 0; b < NUM_BUTTONS; b++)
			bounce_burst(b, 4);
		step(30);
		if (events_seen != 0) begin
			$display("ERR %0t: %0d events from bounce only", $time, events_seen);
			tb_errors++;
		end

		for (int r = 0; r < 2; r++) begin
			for (int b = 0; b < NUM_BUTTONS; b++) begin
				base = events_seen;
				set_button(b, 1'b1);
				wait_events(base + 1, 60);
				set_button(b, 1'b0);
				wait_events(base + 2, 60);
			end
		end

		// all four at once come out lowest id first
		base = events_seen;
		raw_btn = '1;
		step(40);
		wait_events(base + 4, 80);
		for (int k = 0; k < NUM_BUTTONS; k++) begin
			if (seen_q.size() > base + k &&
				(seen_q[base + k].id != button_id_t'(k) || !seen_q[base + k].pressed)) begin
				$display("ERR %0t: simultaneous press %0d came out as id %0d", $time, k,
					seen_q[base + k].id);
				tb_errors++;
			end
		end
		raw_btn = '0;
		step(40);
		wait_events(base + 8, 80);

		// back-pressure with two edges per button
		base = events_seen;
		drain = 1'b0;
		for (int b = 0; b < NUM_BUTTONS; b++) begin
			raw_btn[b] = 1'b1;
			step(25);
			raw_btn[b] = 1'b0;
			step(25);
		end
		if (events_seen != base) begin
			$display("ERR %0t: events consumed while drain was low", $time);
			tb_errors++;
		end
		for (int i = 0; i < 400 && events_seen < base + 8; i++) begin
			rnd = $random(seed);
			drain = rnd[0];
			step(1);
		end
		drain = 1'b1;
		wait_events(base + 8, 50);
		step(30);

		i_checker.final_check();
		total_errors = tb_errors + i_checker.error_count;
		$display("errors: checker %0d, testbench %0d", i_checker.error_count, tb_errors);
		if (total_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: tests/panel_checker.sv
module panel_checker
	import button_pkg::*;
(
	input logic       clk,
	input logic       reset,
	input btn_mask_t  raw_btn,
	input btn_mask_t  level,
	input logic       event_valid,
	input btn_event_t last_event,
	input btn_count_t press_total [NUM_BUTTONS],
	input btn_count_t release_total [NUM_BUTTONS],
	input btn_count_t dropped
);
	timeunit 1ns;
	timeprecision 1ps;

	// 2 sync cycles plus a full window plus one for the level register
	localparam int SETTLE = 2 + (1 << DEBOUNCE_BITS) + 1;

	int error_count = 0;
	int run_len [NUM_BUTTONS];
	int pending_cnt [NUM_BUTTONS];
	logic next_press [NUM_BUTTONS];
	btn_mask_t prev_raw;
	btn_mask_t exp_level;
	btn_count_t exp_press [NUM_BUTTONS];
	btn_count_t exp_release [NUM_BUTTONS];
	logic new_lvl;
	logic drop_seen;

	function automatic int update_run(int run, logic raw, logic prev);
		if (raw != prev)
			return 1;
		return (run < 255) ? run + 1 : run;
	endfunction

	// level takes raw once it has been stable for the whole settle time
	function automatic logic next_level(logic cur, logic raw, int run);
		return (run == SETTLE) ? raw : cur;
	endfunction

	task automatic check_totals();
		for (int i = 0; i < NUM_BUTTONS; i++) begin
			if (press_total[i] !== exp_press[i] || release_total[i] !== exp_release[i]) begin
				$display("ERR %0t: button %0d totals %0d/%0d, expected %0d/%0d", $time, i,
					press_total[i], release_total[i], exp_press[i], exp_release[i]);
				error_count++;
			end
		end
	endtask

	task automatic check_event();
		int id;
		id = int'(last_event.id);
		if (pending_cnt[id] == 0) begin
			$display("ERR %0t: unexpected event for button %0d", $time, id);
			error_count++;
		end else if (last_event.pressed !== next_press[id]) begin
			$display("ERR %0t: button %0d event direction %0b out of order", $time, id,
				last_event.pressed);
			error_count++;
		end else begin
			pending_cnt[id]--;
			next_press[id] = ~next_press[id];
			if (last_event.pressed)
				exp_press[id] = exp_press[id] + 1'b1;
			else
				exp_release[id] = exp_release[id] + 1'b1;
		end
		check_totals();
	endtask

	// outputs are sampled half a cycle after the edge
	always @(negedge clk) begin
		if (reset) begin
			prev_raw = raw_btn;
			exp_level = '0;
			drop_seen = 1'b0;
			for (int i = 0; i < NUM_BUTTONS; i++) begin
				run_len[i] = 0;
				pending_cnt[i] = 0;
				next_press[i] = 1'b1;
				exp_press[i] = '0;
				exp_release[i] = '0;
			end
		end else begin
			for (int i = 0; i < NUM_BUTTONS; i++) begin
				run_len[i] = update_run(run_len[i], raw_btn[i], prev_raw[i]);
				new_lvl = next_level(exp_level[i], raw_btn[i], run_len[i]);
				if (new_lvl != exp_level[i])
					pending_cnt[i]++;
				exp_level[i] = new_lvl;
				// no check near the settle point
				if ((run_len[i] < SETTLE - 3 || run_len[i] > SETTLE) &&
					level[i] !== exp_level[i]) begin
					$display("ERR %0t: button %0d level %0b, expected %0b", $time, i,
						level[i], exp_level[i]);
					error_count++;
				end
			end
			prev_raw = raw_btn;
			if (dropped !== '0 && !drop_seen) begin
				$display("ERR %0t: dropped is %0d, expected 0", $time, dropped);
				error_count++;
				drop_seen = 1'b1;
			end
			if (event_valid)
				check_event();
		end
	end

	task automatic final_check();
		for (int i = 0; i < NUM_BUTTONS; i++) begin
			if (pending_cnt[i] != 0) begin
				$display("ERR %0t: button %0d has %0d events never consumed", $time, i,
					pending_cnt[i]);
				error_count++;
			end
		end
		check_totals();
	endtask

endmodule

// File: verilog/button_panel.sv
module button_panel
	import button_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  btn_mask_t  raw_btn,
	input  logic       drain,
	output btn_mask_t  level,
	output logic       event_valid,
	output btn_event_t last_event,
	output btn_count_t press_total [NUM_BUTTONS],
	output btn_count_t release_total [NUM_BUTTONS],
	output btn_count_t dropped
);

	btn_mask_t posedge_pulse;
	btn_mask_t negedge_pulse;

	// encoder to fifo, credit flow control
	logic push;
	btn_event_t push_event;
	logic credit_return;

	// fifo to consumer
	logic pop;
	logic not_empty;
	btn_event_t head_event;

	button_debouncer u_debouncer (
		.clk           (clk),
		.reset         (reset),
		.raw_btn       (raw_btn),
		.level         (level),
		.posedge_pulse (posedge_pulse),
		.negedge_pulse (negedge_pulse)
	);

	button_event_encoder u_encoder (
		.clk           (clk),
		.reset         (reset),
		.level         (level),
		.posedge_pulse (posedge_pulse),
		.negedge_pulse (negedge_pulse),
		.credit_return (credit_return),
		.push          (push),
		.push_event    (push_event),
		.dropped       (dropped)
	);

	event_fifo u_fifo (
		.clk           (clk),
		.reset         (reset),
		.push          (push),
		.push_event    (push_event),
		.pop           (pop),
		.not_empty     (not_empty),
		.head_event    (head_event),
		.credit_return (credit_return)
	);

	press_counter u_counter (
		.clk           (clk),
		.reset         (reset),
		.drain         (drain),
		.not_empty     (not_empty),
		.head_event    (head_event),
		.pop           (pop),
		.event_valid   (event_valid),
		.last_event    (last_event),
		.press_total   (press_total),
		.release_total (release_total)
	);

endmodule

// File: verilog/press_counter.sv
module press_counter
	import button_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       drain,
	input  logic       not_empty,
	input  btn_event_t head_event,
	output logic       pop,
	output logic       event_valid,
	output btn_event_t last_event,
	output btn_count_t press_total [NUM_BUTTONS],
	output btn_count_t release_total [NUM_BUTTONS]
);

	// drain is the external back-pressure
	assign pop = drain && not_empty;

	always_ff @(posedge clk) begin
		if (reset)
			event_valid <= 1'b0;
		else
			event_valid <= pop;
	end

	always_ff @(posedge clk) begin
		if (pop)
			last_event <= head_event;
	end

	// totals wrap at 256
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_BUTTONS; i++) begin
				press_total[i] <= '0;
				release_total[i] <= '0;
			end
		end else if (pop) begin
			if (head_event.pressed)
				press_total[head_event.id] <= press_total[head_event.id] + 1'b1;
			else
				release_total[head_event.id] <= release_total[head_event.id] + 1'b1;
		end
	end

endmodule

// File: verilog/event_fifo.sv
module event_fifo
	import button_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       push,
	input  btn_event_t push_event,
	input  logic       pop,
	output logic       not_empty,
	output btn_event_t head_event,
	output logic       credit_return
);

	btn_event_t mem [FIFO_DEPTH];
	fifo_ptr_t wr_ptr;
	fifo_ptr_t rd_ptr;
	credit_t occupancy;

	assign not_empty = (occupancy != '0);
	assign head_event = mem[rd_ptr];

	// storage, the sender never pushes without a credit
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_event;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			occupancy <= '0;
		end else begin
			case ({push, pop})
				2'b10: occupancy <= occupancy + 1'b1;
				2'b01: occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
		end
	end

	// credit comes back the cycle after the slot frees
	always_ff @(posedge clk) begin
		if (reset)
			credit_return <= 1'b0;
		else
			credit_return <= pop;
	end

endmodule

// File: verilog/button_event_encoder.sv
module button_event_encoder
	import button_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  btn_mask_t  level,
	input  btn_mask_t  posedge_pulse,
	input  btn_mask_t  negedge_pulse,
	input  logic       credit_return,
	output logic       push,
	output btn_event_t push_event,
	output btn_count_t dropped
);

	btn_mask_t press_pend;
	btn_mask_t rel_pend;
	// set when the pending release is older than the pending press
	btn_mask_t rel_first;
	btn_mask_t both_pend;
	btn_mask_t new_edge;
	btn_mask_t clear_press;
	btn_mask_t clear_rel;
	credit_t credits;
	button_id_t sel_id;
	logic sel_pressed;

	assign both_pend = press_pend & rel_pend;
	assign new_edge = (posedge_pulse | negedge_pulse) & ~both_pend;

	// scan downward so the lowest pending index is left selected
	always_comb begin
		sel_id = '0;
		sel_pressed = 1'b0;
		for (int i = NUM_BUTTONS - 1; i >= 0; i--) begin
			if (press_pend[i] || rel_pend[i]) begin
				sel_id = button_id_t'(i);
				sel_pressed = both_pend[i] ? ~rel_first[i] : press_pend[i];
			end
		end
	end

	assign push = (|(press_pend | rel_pend)) && (credits != '0);
	assign push_event = '{id: sel_id, pressed: sel_pressed};

	always_comb begin
		clear_press = '0;
		clear_rel = '0;
		if (push) begin
			if (sel_pressed)
				clear_press[sel_id] = 1'b1;
			else
				clear_rel[sel_id] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			press_pend <= '0;
			rel_pend <= '0;
			rel_first <= '0;
			dropped <= '0;
		end else begin
			press_pend <= (press_pend & ~clear_press) | (posedge_pulse & ~both_pend);
			rel_pend <= (rel_pend & ~clear_rel) | (negedge_pulse & ~both_pend);
			// a press (level high) goes behind any pending release
			rel_first <= (rel_first & ~new_edge) | (level & new_edge);
			dropped <= dropped + btn_count_t'($countones(
				(posedge_pulse | negedge_pulse) & both_pend));
		end
	end

	// one credit per push, one back per returned slot
	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= credit_t'(FIFO_DEPTH);
		end else begin
			case ({push, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

// File: verilog/button_debouncer.sv
module button_debouncer
	import button_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  btn_mask_t raw_btn,
	output btn_mask_t level,
	output btn_mask_t posedge_pulse,
	output btn_mask_t negedge_pulse
);

	// two-flop synchroniser stages
	btn_mask_t sync_meta;
	btn_mask_t sync_q;

	// previous debounced level for edge detection
	btn_mask_t level_d;

	btn_mask_t changed;
	debounce_cnt_t stable_cnt [NUM_BUTTONS];

	assign changed = sync_meta ^ sync_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_meta <= '0;
			sync_q <= '0;
		end else begin
			sync_meta <= raw_btn;
			sync_q <= sync_meta;
		end
	end

	// per-button window counter, restarts on any change and saturates
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_BUTTONS; i++) begin
				stable_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_BUTTONS; i++) begin
				if (changed[i])
					stable_cnt[i] <= '0;
				else if (!(&stable_cnt[i]))
					stable_cnt[i] <= stable_cnt[i] + 1'b1;
			end
		end
	end

	// level only follows the input once the window is full
	always_ff @(posedge clk) begin
		if (reset) begin
			level <= '0;
		end else begin
			for (int i = 0; i < NUM_BUTTONS; i++) begin
				if (&stable_cnt[i])
					level[i] <= sync_q[i];
			end
		end
	end

	// registered edges, one cycle after level moves
	always_ff @(posedge clk) begin
		if (reset) begin
			level_d <= '0;
			posedge_pulse <= '0;
			negedge_pulse <= '0;
		end else begin
			level_d <= level;
			posedge_pulse <= level & ~level_d;
			negedge_pulse <= ~level & level_d;
		end
	end

endmodule

// File: verilog/button_pkg.sv
package button_pkg;

	localparam int NUM_BUTTONS = 4;

	// stability counter width, window is 2**DEBOUNCE_BITS cycles
	localparam int DEBOUNCE_BITS = 4;

	// event slots, also the credits held after reset
	localparam int FIFO_DEPTH = 4;
	localparam int CREDIT_BITS = 3;
	localparam int PTR_BITS = $clog2(FIFO_DEPTH);

	localparam int COUNT_BITS = 8;

	typedef logic [NUM_BUTTONS-1:0] btn_mask_t;
	typedef logic [1:0] button_id_t;
	typedef logic [COUNT_BITS-1:0] btn_count_t;
	typedef logic [DEBOUNCE_BITS-1:0] debounce_cnt_t;
	typedef logic [CREDIT_BITS-1:0] credit_t;
	typedef logic [PTR_BITS-1:0] fifo_ptr_t;

	// pressed is 1 for a press, 0 for a release
	typedef struct packed {
		button_id_t id;
		logic pressed;
	} btn_event_t;

endpackage
